/* run.sh */
#!/bin/sh
# Build and run the PWL generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module pwl_tb \
	-Mdir obj_dir -o pwl_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/pwl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sources.f */
src/pwl_pkg.sv
src/interpolator.sv
src/wave_store.sv
src/pwl_generator.sv
src/pwl_top.sv
verif/pwl_tb.sv

/* src/interpolator.sv */
`timescale 1ns/1ps

module interpolator
	import pwl_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic clk,
	input  sample_t x,
	input  sample_t slope,
	output logic [BATCH_SIZE*SAMPLE_W-1:0] batch
);

	sample_t x_s1;
	sample_t slope_s1;
	sample_t x_s2;
	sample_t prod_s2 [BATCH_SIZE];

	// Stage one, input capture
	always_ff @(posedge clk) begin
		x_s1 <= x;
		slope_s1 <= slope;
	end

	// Stage two, slope times lane index
	always_ff @(posedge clk) begin
		x_s2 <= x_s1;
		for (int k = 0; k < BATCH_SIZE; k++) begin
			prod_s2[k] <= slope_s1 * sample_t'(k);
		end
	end

	// Stage three, lane sums (wrap modulo 2^16)
	always_ff @(posedge clk) begin
		for (int k = 0; k < BATCH_SIZE; k++) begin
			batch[k*SAMPLE_W +: SAMPLE_W] <= x_s2 + prod_s2[k];
		end
	end

endmodule

/* src/pwl_generator.sv */
`timescale 1ns/1ps

module pwl_generator
	import pwl_pkg::*;
#(
	parameter int BATCH_SIZE = 4,
	parameter int SPARSE_DEPTH = 32,
	parameter int DENSE_DEPTH = 32
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic halt,
	input  dma_word_t dma_data,
	input  logic dma_valid,
	output logic dma_ready,
	output logic rdy_to_run,
	output logic [BATCH_SIZE*SAMPLE_W-1:0] batch_out,
	output logic valid_batch_out
);

	localparam int BW = BATCH_SIZE*SAMPLE_W;
	localparam int SPARSE_W = $bits(dma_word_t) + 1;
	localparam int DENSE_W = BW + 1;
	localparam int SA_W = $clog2(SPARSE_DEPTH);
	localparam int DA_W = $clog2(DENSE_DEPTH);
	localparam int PTR_W = $clog2(BATCH_SIZE) + 1;
	localparam int B_SHIFT = $clog2(BATCH_SIZE);
	localparam sample_t B_LEN = sample_t'(BATCH_SIZE);

	typedef enum logic [3:0] {
		IDLE, DENSE_WAIT, STORE_DENSE, STORE_SPARSE, SETUP_PLAY,
		SEND_DENSE, SEND_SPARSE, HOLD_SPARSE, HALTING
	} gen_state_t;

	gen_state_t state;

	// Input pipe, cur is the word being handled, nxt the one behind it
	dma_word_t cur_word, nxt_word;
	logic cur_v, nxt_v;
	sample_t cur_x, cur_slope, cur_dt;
	logic cur_sb, nxt_sb, first_sb, first_kind;
	logic take, s_sw, d_sw, wr_ok;

	// Store ports
	logic [SA_W-1:0] s_addr, s_cnt;
	logic [DA_W-1:0] d_addr, d_cnt;
	logic [SPARSE_W-1:0] s_line_in, s_line_out;
	logic [DENSE_W-1:0] d_line_in, d_line_out;
	logic s_we, d_we, s_next, d_next, play, play_rst;
	logic s_valid, d_valid, s_wrdy, d_wrdy;

	// Interpolator and load-side delay pipe
	sample_t intrp_x, intrp_slope;
	logic [BW-1:0] intrp_batch;
	logic [2:0] lp_v, lp_sw;
	sample_t lp_dt [3];
	logic [PTR_W-1:0] batch_ptr;
	logic [BW-1:0] line_acc, merged;

	// Playback
	sample_t sp_x, sp_slope, sp_dt;
	sample_t x_reg, slope_reg, dt_reg;
	logic hold_sw, emit;
	logic [2:0] o_v, o_sel;
	logic [2:0][BW-1:0] o_dense;

	wave_store #(.DATA_WIDTH(SPARSE_W), .DEPTH(SPARSE_DEPTH)) sparse_store (
		.clk(clk), .rst(rst),
		.addr(s_addr), .line_in(s_line_in), .we(s_we), .en(s_we),
		.next(s_next), .play(play), .play_rst(play_rst),
		.line_out(s_line_out), .valid_line_out(s_valid), .write_rdy(s_wrdy)
	);

	wave_store #(.DATA_WIDTH(DENSE_W), .DEPTH(DENSE_DEPTH)) dense_store (
		.clk(clk), .rst(rst),
		.addr(d_addr), .line_in(d_line_in), .we(d_we), .en(d_we),
		.next(d_next), .play(play), .play_rst(play_rst),
		.line_out(d_line_out), .valid_line_out(d_valid), .write_rdy(d_wrdy)
	);

	interpolator #(.BATCH_SIZE(BATCH_SIZE)) interp (
		.clk(clk), .x(intrp_x), .slope(intrp_slope), .batch(intrp_batch)
	);

	// --------------------
	// Decode and steering
	// --------------------
	always_comb begin
		cur_x = cur_word[X_LSB +: SAMPLE_W];
		cur_slope = cur_word[SLOPE_LSB +: SAMPLE_W];
		cur_dt = {1'b0, cur_word[SAMPLE_W-1:1]};
		cur_sb = cur_word[0];
		nxt_sb = nxt_word[0];
		sp_x = s_line_out[X_LSB +: SAMPLE_W];
		sp_slope = s_line_out[SLOPE_LSB +: SAMPLE_W];
		sp_dt = {1'b0, s_line_out[SAMPLE_W-1:1]};

		take = dma_ready && cur_v &&
			(state == IDLE || state == STORE_DENSE || state == STORE_SPARSE);
		first_kind = (state == IDLE) ? cur_sb : first_sb;
		// Last word wraps to the first one
		s_sw = nxt_v ? !nxt_sb : !first_kind;
		d_sw = nxt_v ? nxt_sb : first_kind;
		wr_ok = s_wrdy && d_wrdy;

		emit = !halt && (state == SEND_DENSE || state == SEND_SPARSE
			|| state == HOLD_SPARSE);
		d_next = emit && state == SEND_DENSE;
		s_next = emit && state == SEND_SPARSE;

		case (state)
			HOLD_SPARSE: begin
				intrp_x = x_reg;
				intrp_slope = slope_reg;
			end
			SEND_SPARSE: begin
				intrp_x = sp_x;
				intrp_slope = sp_slope;
			end
			default: begin
				intrp_x = cur_x;
				intrp_slope = cur_slope;
			end
		endcase

		valid_batch_out = o_v[2];
		batch_out = o_sel[2] ? intrp_batch : o_dense[2];
	end

	// Place the first dt lanes of a result at batch_ptr
	always_comb begin
		int lane;
		merged = line_acc;
		for (int k = 0; k < BATCH_SIZE; k++) begin
			lane = k - int'(batch_ptr);
			if (lane >= 0 && lane < int'(lp_dt[2])) begin
				merged[k*SAMPLE_W +: SAMPLE_W] = intrp_batch[lane*SAMPLE_W +: SAMPLE_W];
			end
		end
	end

	// --------------------
	// Pipes
	// --------------------
	always_ff @(posedge clk) begin
		if (dma_ready) begin
			nxt_word <= dma_data;
			cur_word <= nxt_word;
		end
		lp_dt[0] <= cur_dt;
		lp_dt[1] <= lp_dt[0];
		lp_dt[2] <= lp_dt[1];
		lp_sw <= {lp_sw[1:0], d_sw};
		o_sel <= {o_sel[1:0], state != SEND_DENSE};
		o_dense <= {o_dense[1:0], d_line_out[BW-1:0]};
		if (rst) begin
			nxt_v <= 1'b0;
			cur_v <= 1'b0;
			lp_v <= '0;
			o_v <= '0;
		end else begin
			if (dma_ready) begin
				nxt_v <= dma_valid;
				cur_v <= nxt_v;
			end
			lp_v <= {lp_v[1:0], take && !cur_sb};
			o_v <= {o_v[1:0], emit};
		end
	end

	// --------------------
	// Main FSM
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			dma_ready <= 1'b1;
			rdy_to_run <= 1'b0;
			first_sb <= 1'b0;
			s_we <= 1'b0;
			d_we <= 1'b0;
			s_cnt <= '0;
			d_cnt <= '0;
			batch_ptr <= '0;
			play <= 1'b0;
			play_rst <= 1'b0;
		end else begin
			s_we <= 1'b0;
			d_we <= 1'b0;

			// Dense line assembly from the interpolator
			if (lp_v[2]) begin
				if ({{(SAMPLE_W-PTR_W){1'b0}}, batch_ptr} + lp_dt[2] == B_LEN) begin
					d_we <= 1'b1;
					d_addr <= d_cnt;
					d_line_in <= {lp_sw[2], merged};
					d_cnt <= d_cnt + 1'b1;
					batch_ptr <= '0;
				end else begin
					line_acc <= merged;
					batch_ptr <= batch_ptr + PTR_W'(lp_dt[2]);
				end
			end

			case (state)
				IDLE, STORE_DENSE, STORE_SPARSE: begin
					dma_ready <= wr_ok;
					if (take) begin
						if (state == IDLE) begin
							first_sb <= cur_sb; // New upload replaces the old one
							rdy_to_run <= 1'b0;
							s_cnt <= '0;
							d_cnt <= '0;
							batch_ptr <= '0;
						end
						if (cur_sb) begin
							s_we <= 1'b1;
							s_line_in <= {s_sw, cur_word};
							s_addr <= (state == IDLE) ? '0 : s_cnt;
							s_cnt <= ((state == IDLE) ? '0 : s_cnt) + 1'b1;
						end
						// Drain before a sparse word or at the end
						if (!nxt_v || (!cur_sb && nxt_sb)) begin
							dma_ready <= 1'b0;
							state <= DENSE_WAIT;
						end else begin
							state <= cur_sb ? STORE_SPARSE : STORE_DENSE;
						end
					end else if (state == IDLE && run && rdy_to_run) begin
						dma_ready <= 1'b0;
						rdy_to_run <= 1'b0;
						play <= 1'b1;
						state <= SETUP_PLAY;
					end
				end

				DENSE_WAIT: begin
					dma_ready <= 1'b0;
					if (lp_v == '0) begin
						if (cur_v) begin
							dma_ready <= 1'b1;
							state <= STORE_SPARSE;
						end else begin
							rdy_to_run <= 1'b1;
							state <= IDLE;
						end
					end
				end

				SETUP_PLAY: begin
					dma_ready <= 1'b0;
					if (first_sb ? s_valid : d_valid) begin
						state <= first_sb ? SEND_SPARSE : SEND_DENSE;
					end
				end

				SEND_DENSE: begin
					if (halt) begin
						play <= 1'b0;
						play_rst <= 1'b1;
						state <= HALTING;
					end else if (d_line_out[BW]) begin
						state <= SEND_SPARSE;
					end
				end

				SEND_SPARSE: begin
					if (halt) begin
						play <= 1'b0;
						play_rst <= 1'b1;
						state <= HALTING;
					end else if (sp_dt == B_LEN) begin
						if (s_line_out[SPARSE_W-1]) state <= SEND_DENSE;
					end else begin
						// Longer command, keep expanding it
						x_reg <= sp_x + (sp_slope << B_SHIFT);
						slope_reg <= sp_slope;
						dt_reg <= sp_dt - B_LEN;
						hold_sw <= s_line_out[SPARSE_W-1];
						state <= HOLD_SPARSE;
					end
				end

				HOLD_SPARSE: begin
					if (halt) begin
						play <= 1'b0;
						play_rst <= 1'b1;
						state <= HALTING;
					end else begin
						x_reg <= x_reg + (slope_reg << B_SHIFT);
						if (dt_reg == B_LEN) state <= hold_sw ? SEND_DENSE : SEND_SPARSE;
						else dt_reg <= dt_reg - B_LEN;
					end
				end

				HALTING: begin
					play_rst <= 1'b0;
					if (o_v == '0) begin // Output drained
						rdy_to_run <= 1'b1;
						state <= IDLE;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* src/pwl_pkg.sv */
package pwl_pkg;

	// DAC sample width
	localparam int SAMPLE_W = 16;

	// One sample, also used for x, slope and dt
	typedef logic [SAMPLE_W-1:0] sample_t;

	// --------------------
	// Host command word
	// --------------------
	// {x, slope, dt[SAMPLE_W-2:0], sb}, top bit of dt reads as zero
	typedef logic [3*SAMPLE_W-1:0] dma_word_t;

	localparam int X_LSB = 2*SAMPLE_W;
	localparam int SLOPE_LSB = SAMPLE_W;

endpackage

/* src/pwl_top.sv */
`timescale 1ns/1ps

module pwl_top
	import pwl_pkg::*;
#(
	parameter int BATCH_SIZE = 4,
	parameter int SPARSE_DEPTH = 32,
	parameter int DENSE_DEPTH = 32
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic halt,
	input  dma_word_t dma_data,
	input  logic dma_valid,
	output logic dma_ready,
	output logic rdy_to_run,
	output logic [BATCH_SIZE*SAMPLE_W-1:0] batch_out,
	output logic valid_batch_out
);

	pwl_generator #(
		.BATCH_SIZE(BATCH_SIZE),
		.SPARSE_DEPTH(SPARSE_DEPTH),
		.DENSE_DEPTH(DENSE_DEPTH)
	) gen (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halt(halt),
		.dma_data(dma_data),
		.dma_valid(dma_valid),
		.dma_ready(dma_ready),
		.rdy_to_run(rdy_to_run),
		.batch_out(batch_out),
		.valid_batch_out(valid_batch_out)
	);

endmodule

/* src/wave_store.sv */
`timescale 1ns/1ps

module wave_store #(
	parameter int DATA_WIDTH = 49,
	parameter int DEPTH = 32,
	localparam int ADDR_W = $clog2(DEPTH)
) (
	input  logic clk,
	input  logic rst,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_WIDTH-1:0] line_in,
	input  logic we,
	input  logic en,
	input  logic next,
	input  logic play,
	input  logic play_rst,
	output logic [DATA_WIDTH-1:0] line_out,
	output logic valid_line_out,
	output logic write_rdy
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];
	logic [ADDR_W:0] wave_len; // Lines in the stored waveform
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] nxt_ptr;
	logic play_d;

	// --------------------
	// Write side
	// --------------------
	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= line_in;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wave_len <= '0;
		end else if (en && we) begin
			// Address 0 starts a new waveform
			if (addr == '0 || {1'b0, addr} >= wave_len) begin
				wave_len <= {1'b0, addr} + 1'b1;
			end
		end
	end

	assign write_rdy = !play && !play_rst;

	// --------------------
	// Playback side
	// --------------------
	always_comb begin
		if ({1'b0, rd_ptr} == wave_len - 1'b1) nxt_ptr = '0; // Loop back
		else nxt_ptr = rd_ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			valid_line_out <= 1'b0;
			play_d <= 1'b0;
		end else if (play_rst) begin
			rd_ptr <= '0;
			valid_line_out <= 1'b0;
			play_d <= 1'b0;
		end else begin
			play_d <= play;
			if (play && !play_d) begin
				rd_ptr <= '0;
				valid_line_out <= (wave_len != '0);
			end else if (play && next) begin
				rd_ptr <= nxt_ptr;
			end
		end
	end

	// Synchronous read
	always_ff @(posedge clk) begin
		if (play && !play_d) line_out <= mem[0];
		else if (play && next) line_out <= mem[nxt_ptr];
	end

endmodule

/* verif/pwl_tb.sv */
`timescale 1ns/1ps

module pwl_tb
	import pwl_pkg::*;
();

	localparam int BATCH_SIZE = 4;
	localparam int BW = BATCH_SIZE*SAMPLE_W;

	logic clk;
	logic rst;
	logic run;
	logic halt;
	dma_word_t dma_data;
	logic dma_valid;
	logic dma_ready;
	logic rdy_to_run;
	logic [BW-1:0] batch_out;
	logic valid_batch_out;

	integer seed = 1008;
	dma_word_t wave [$]; // Segment commands of the stored waveform
	int sample_idx = 0; // Next expected waveform index
	int test_batches = 0;
	int sample_errors = 0;
	int flag_errors = 0;
	int other_errors = 0;
	string test_name = "reset";

	pwl_top #(.BATCH_SIZE(BATCH_SIZE), .SPARSE_DEPTH(32), .DENSE_DEPTH(32)) dut (
		.clk(clk), .rst(rst), .run(run), .halt(halt),
		.dma_data(dma_data), .dma_valid(dma_valid), .dma_ready(dma_ready),
		.rdy_to_run(rdy_to_run), .batch_out(batch_out), .valid_batch_out(valid_batch_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------
	// Reference model
	// --------------------
	function automatic sample_t expected_sample(input dma_word_t segs [$], input int n);
		int total;
		int m;
		sample_t res;
		total = 0;
		res = '0;
		foreach (segs[i]) total += int'(segs[i][SAMPLE_W-1:1]);
		m = n % total; // Playback loops
		foreach (segs[i]) begin
			if (m >= 0 && m < int'(segs[i][SAMPLE_W-1:1])) begin
				res = segs[i][3*SAMPLE_W-1 -: SAMPLE_W]
					+ segs[i][2*SAMPLE_W-1 -: SAMPLE_W] * sample_t'(m);
			end
			m -= int'(segs[i][SAMPLE_W-1:1]);
		end
		return res;
	endfunction

	function automatic int rand_below(input int n);
		return int'(($random(seed) & 32'h7fff_ffff) % n);
	endfunction

	// Random x and slope
	function automatic dma_word_t random_cmd(input int dt, input logic sb);
		sample_t d;
		d = sample_t'(dt);
		return {sample_t'($random(seed)), sample_t'($random(seed)), d[SAMPLE_W-2:0], sb};
	endfunction

	// Whole batches cut into random dense pieces
	task automatic add_dense(input int nbatches);
		int rem;
		int d;
		for (int b = 0; b < nbatches; b++) begin
			rem = BATCH_SIZE;
			while (rem > 0) begin
				d = 1 + rand_below(rem);
				wave.push_back(random_cmd(d, 1'b0));
				rem -= d;
			end
		end
	endtask

	task automatic add_sparse(input int nbatches);
		wave.push_back(random_cmd(nbatches*BATCH_SIZE, 1'b1));
	endtask

	function automatic int wave_batches();
		int total;
		total = 0;
		foreach (wave[i]) total += int'(wave[i][SAMPLE_W-1:1]);
		return total / BATCH_SIZE;
	endfunction

	// --------------------
	// Checks
	// --------------------
	task automatic check_sample(input string name, input int idx, input sample_t exp,
		input sample_t act);
		if (act !== exp) begin
			$display("FAIL %s sample %0d: expected %h, actual %h", name, idx, exp, act);
			sample_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			flag_errors++;
		end
	endtask

	always @(negedge clk) begin
		if (!rst && valid_batch_out) begin
			for (int k = 0; k < BATCH_SIZE; k++) begin
				check_sample(test_name, sample_idx + k, expected_sample(wave, sample_idx + k),
					batch_out[k*SAMPLE_W +: SAMPLE_W]);
			end
			sample_idx += BATCH_SIZE;
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	task automatic load_wave(input string name);
		int n;
		logic seen_low;
		test_name = name;
		seen_low = !rdy_to_run; // Old waveform may still report ready
		foreach (wave[i]) begin
			@(negedge clk);
			dma_data = wave[i];
			dma_valid = 1'b1;
			while (!dma_ready) @(negedge clk); // Hold the word
			if (!rdy_to_run) seen_low = 1'b1;
		end
		@(negedge clk);
		dma_valid = 1'b0;
		if (!rdy_to_run) seen_low = 1'b1;
		// Last word went in on the edge before, ready is due within 8 cycles
		n = 0;
		while (!(seen_low && rdy_to_run) && n < 8) begin
			@(negedge clk);
			n++;
			if (!rdy_to_run) seen_low = 1'b1;
		end
		if (!seen_low) begin
			$display("rdy_to_run stayed high during the %s upload", name);
			other_errors++;
		end else if (!rdy_to_run) begin
			$display("rdy_to_run did not rise within 8 cycles of the %s upload", name);
			other_errors++;
		end
	endtask

	task automatic play_and_check(input string name, input int nbatches);
		int n;
		test_name = name;
		test_batches += nbatches;
		@(negedge clk);
		sample_idx = 0;
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		n = 0;
		while (!valid_batch_out && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (!valid_batch_out) begin
			$display("No batch came out within 50 cycles of run in %s", name);
			other_errors++;
		end
		repeat (nbatches) begin
			check_flag({name, " stream without gaps"}, 1'b1, valid_batch_out);
			@(negedge clk);
		end
		halt = 1'b1;
		@(negedge clk);
		halt = 1'b0;
		n = 0;
		while (valid_batch_out && n < 5) begin
			@(negedge clk);
			n++;
		end
		check_flag({name, " valid_batch_out after halt"}, 1'b0, valid_batch_out);
		n = 0;
		while (!rdy_to_run && n < 2) begin
			@(negedge clk);
			n++;
		end
		check_flag({name, " rdy_to_run after halt"}, 1'b1, rdy_to_run);
	endtask

	// Limit grows with the streamed batches
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= 4*test_batches + 2000) begin
			@(posedge clk);
			cycles++;
		end
		$display("Watchdog expired after %0d cycles, run stopped", cycles);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		run = 1'b0;
		halt = 1'b0;
		dma_data = '0;
		dma_valid = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("reset rdy_to_run", 1'b0, rdy_to_run);
		check_flag("reset valid_batch_out", 1'b0, valid_batch_out);
		check_flag("reset dma_ready", 1'b1, dma_ready);

		add_dense(6);
		load_wave("dense");
		play_and_check("dense", 3*wave_batches());

		wave.delete();
		repeat (6) add_sparse(1 + rand_below(4));
		load_wave("sparse");
		play_and_check("sparse", 3*wave_batches());

		wave.delete(); // Mixed, dense run first
		add_dense(2);
		add_sparse(2);
		add_sparse(1);
		add_dense(3);
		add_sparse(3);
		load_wave("mixed_dense_first");
		play_and_check("mixed_dense_first", 3*wave_batches());

		wave.delete(); // Mixed, sparse first, halted mid-loop
		add_sparse(2);
		add_dense(1);
		add_sparse(1);
		add_sparse(3);
		add_dense(2);
		load_wave("halt");
		play_and_check("halt", wave_batches() + 3);
		play_and_check("replay", 3*wave_batches());

		wave.delete(); // Shorter replacement
		add_sparse(1);
		add_dense(1);
		load_wave("reload");
		play_and_check("reload", 3*wave_batches());

		$display("Errors: %0d sample, %0d flag, %0d other", sample_errors, flag_errors,
			other_errors);
		if (sample_errors + flag_errors + other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
